// File: recovery_pkg.sv
// shared recovery types; state and kind encodings are fixed widths that the testbench relies on
`default_nettype none

package recovery_pkg;

  // recovery controller states, one routine per faulty DMR group
  // EXIT is a single cycle that releases the selected group
  typedef enum logic [2:0] {
    IDLE,
    SETBACK,
    HALT_REQ,
    HALT_WAIT,
    RESTORE_RF,
    EXIT
  } recovery_state_e;

  // kind of lock-step disagreement seen in one group
  // NO_MISMATCH is the reset value and marks a healthy group
  typedef enum logic [1:0] {
    MAIN_MISMATCH,
    DATA_MISMATCH,
    BOTH_MISMATCH,
    NO_MISMATCH
  } error_kind_e;

endpackage

`default_nettype wire

// File: lockstep_checker.sv
// core words are packed group 0 in the low bits; flags lag the compared inputs by one cycle
`timescale 1ns/1ns
`default_nettype none

module lockstep_checker #(
  parameter int unsigned NumGroups = 4,
  parameter int unsigned DataWidth = 32
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [NumGroups*DataWidth-1:0]        core_a_main_i,
  input  logic [NumGroups*DataWidth-1:0]        core_b_main_i,
  input  logic [NumGroups*DataWidth-1:0]        core_a_data_i,
  input  logic [NumGroups*DataWidth-1:0]        core_b_data_i,
  output logic [NumGroups-1:0]                  fault_mask_o,
  output recovery_pkg::error_kind_e [NumGroups-1:0] error_kind_o
);

  for (genvar g = 0; g < NumGroups; g++) begin : gen_group
    logic                      main_diff;
    logic                      data_diff;
    recovery_pkg::error_kind_e kind_d;

    // the two cores of a group must agree bit for bit on both outputs
    assign main_diff = core_a_main_i[g*DataWidth +: DataWidth] !=
                       core_b_main_i[g*DataWidth +: DataWidth];
    assign data_diff = core_a_data_i[g*DataWidth +: DataWidth] !=
                       core_b_data_i[g*DataWidth +: DataWidth];

    always_comb begin
      case ({main_diff, data_diff})
        2'b11:   kind_d = recovery_pkg::BOTH_MISMATCH;
        2'b10:   kind_d = recovery_pkg::MAIN_MISMATCH;
        2'b01:   kind_d = recovery_pkg::DATA_MISMATCH;
        default: kind_d = recovery_pkg::NO_MISMATCH;
      endcase
    end

    // flags are refreshed every cycle, so a lasting fault stays visible
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        fault_mask_o[g] <= 1'b0;
        error_kind_o[g] <= recovery_pkg::NO_MISMATCH;
      end else begin
        fault_mask_o[g] <= main_diff | data_diff;
        error_kind_o[g] <= kind_d;
      end
    end
  end

endmodule

`default_nettype wire

// File: rf_address_generator.sv
// walks only the lower half of the register file; RfAddrWidth must be at least 2
`timescale 1ns/1ns
`default_nettype none

module rf_address_generator #(
  parameter int unsigned RfAddrWidth = 5
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   enable_i,
  output logic [RfAddrWidth-2:0] addr_o,
  output logic                   last_o
);

  // one address covers a pair of registers, so half the range suffices
  localparam int unsigned HalfWidth = RfAddrWidth - 1;

  logic [HalfWidth-1:0] count_q;
  logic [HalfWidth-1:0] count_d;
  logic                 last;

  // the final pair is reached when every count bit is set
  assign last = &count_q;

  always_comb begin
    count_d = count_q;
    if (!enable_i || last) begin
      // back to the first pair once disabled or after the final one
      count_d = '0;
    end else begin
      count_d = count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign addr_o = count_q;

  // the count is zero while disabled, so last can only rise during a walk
  assign last_o = last;

endmodule

`default_nettype wire

// File: recovery_controller.sv
// one group is handled at a time; faults arriving while busy are seen again only back in idle
`timescale 1ns/1ns
`default_nettype none

module recovery_controller #(
  parameter  int unsigned NumGroups   = 4,
  parameter  int unsigned RfAddrWidth = 5,
  localparam int unsigned GroupW      = (NumGroups > 1) ? $clog2(NumGroups) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [NumGroups-1:0]                  fault_mask_i,
  input  recovery_pkg::error_kind_e [NumGroups-1:0] error_kind_i,
  input  logic [RfAddrWidth-2:0]                addr_i,
  input  logic                                  addr_last_i,
  input  logic [NumGroups-1:0]                  debug_rsp_i,
  output logic                                  addr_gen_en_o,
  output logic [NumGroups-1:0]                  setback_o,
  output logic [NumGroups-1:0]                  debug_req_o,
  output logic [NumGroups-1:0]                  resume_o,
  output logic [NumGroups-1:0]                  recover_o,
  output logic [NumGroups-1:0]                  instr_lock_o,
  output logic [NumGroups-1:0]                  clk_en_o,
  output logic                                  we_a_o,
  output logic                                  we_b_o,
  output logic [RfAddrWidth-1:0]                waddr_a_o,
  output logic [RfAddrWidth-1:0]                waddr_b_o,
  output logic [GroupW-1:0]                     group_o,
  output recovery_pkg::error_kind_e             fault_kind_o,
  output logic                                  busy_o
);

  recovery_pkg::recovery_state_e state_q;
  recovery_pkg::recovery_state_e state_d;
  recovery_pkg::error_kind_e     kind_q;

  logic [GroupW-1:0]    group_q;
  logic [GroupW-1:0]    sel_idx;
  logic [NumGroups-1:0] lock_q;
  logic [NumGroups-1:0] recover_q;
  logic                 start;
  logic                 restore;
  logic                 done;
  logic                 halted;

  assign start   = |fault_mask_i;
  assign restore = state_q == recovery_pkg::RESTORE_RF;
  assign done    = restore && addr_last_i;
  assign halted  = (state_q == recovery_pkg::HALT_WAIT) && debug_rsp_i[group_q];

  // lowest faulty group wins, so scan from the top and let lower hits overwrite
  always_comb begin
    sel_idx = '0;
    for (int i = NumGroups - 1; i >= 0; i--) begin
      if (fault_mask_i[i]) begin
        sel_idx = GroupW'(i);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      recovery_pkg::IDLE: begin
        if (start) begin
          state_d = recovery_pkg::SETBACK;
        end
      end
      recovery_pkg::SETBACK:   state_d = recovery_pkg::HALT_REQ;
      recovery_pkg::HALT_REQ:  state_d = recovery_pkg::HALT_WAIT;
      recovery_pkg::HALT_WAIT: begin
        // the halted group holds its response high, no timeout here
        if (halted) begin
          state_d = recovery_pkg::RESTORE_RF;
        end
      end
      recovery_pkg::RESTORE_RF: begin
        if (addr_last_i) begin
          state_d = recovery_pkg::EXIT;
        end
      end
      recovery_pkg::EXIT:      state_d = recovery_pkg::IDLE;
      default:                 state_d = recovery_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= recovery_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the kind is captured with the group, as the checker may stop flagging it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      group_q <= '0;
      kind_q  <= recovery_pkg::NO_MISMATCH;
    end else if ((state_q == recovery_pkg::IDLE) && start) begin
      group_q <= sel_idx;
      kind_q  <= error_kind_i[sel_idx];
    end else if (state_q == recovery_pkg::EXIT) begin
      group_q <= '0;
      kind_q  <= recovery_pkg::NO_MISMATCH;
    end
  end

  // fetch stays locked from setback until the restore has written its last pair
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= '0;
    end else if (state_q == recovery_pkg::SETBACK) begin
      lock_q[group_q] <= 1'b1;
    end else if (done) begin
      lock_q[group_q] <= 1'b0;
    end
  end

  // recover covers exactly the restore cycles of the selected group
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      recover_q <= '0;
    end else if (halted) begin
      recover_q[group_q] <= 1'b1;
    end else if (done) begin
      recover_q[group_q] <= 1'b0;
    end
  end

  always_comb begin
    setback_o   = '0;
    debug_req_o = '0;
    resume_o    = '0;
    if (state_q == recovery_pkg::SETBACK) begin
      setback_o[group_q] = 1'b1;
    end
    if (state_q == recovery_pkg::HALT_REQ) begin
      debug_req_o[group_q] = 1'b1;
    end
    if (done) begin
      resume_o[group_q] = 1'b1;
    end
  end

  assign recover_o    = recover_q;
  assign instr_lock_o = lock_q;
  // the halt goes through debug mode, so every core keeps its clock
  assign clk_en_o     = '1;

  assign addr_gen_en_o = restore;
  assign we_a_o        = restore;
  assign we_b_o        = restore;

  // port b writes the upper half, i.e. the same offset plus half the register count
  assign waddr_a_o = restore ? {1'b0, addr_i} : '0;
  assign waddr_b_o = restore ? {1'b1, addr_i} : '0;

  assign group_o      = group_q;
  assign fault_kind_o = kind_q;
  assign busy_o       = state_q != recovery_pkg::IDLE;

endmodule

`default_nettype wire

// File: dmr_recovery_top.sv
// register file, cores and PC or CSR restore live outside; core words are packed per group
`timescale 1ns/1ns
`default_nettype none

module dmr_recovery_top #(
  parameter  int unsigned NumGroups   = 4,
  parameter  int unsigned DataWidth   = 32,
  parameter  int unsigned RfAddrWidth = 5,
  localparam int unsigned GroupW      = (NumGroups > 1) ? $clog2(NumGroups) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [NumGroups*DataWidth-1:0] core_a_main_i,
  input  logic [NumGroups*DataWidth-1:0] core_b_main_i,
  input  logic [NumGroups*DataWidth-1:0] core_a_data_i,
  input  logic [NumGroups*DataWidth-1:0] core_b_data_i,
  input  logic [NumGroups-1:0]           debug_rsp_i,
  output logic [NumGroups-1:0]           setback_o,
  output logic [NumGroups-1:0]           debug_req_o,
  output logic [NumGroups-1:0]           resume_o,
  output logic [NumGroups-1:0]           recover_o,
  output logic [NumGroups-1:0]           instr_lock_o,
  output logic [NumGroups-1:0]           clk_en_o,
  output logic                           we_a_o,
  output logic                           we_b_o,
  output logic [RfAddrWidth-1:0]         waddr_a_o,
  output logic [RfAddrWidth-1:0]         waddr_b_o,
  output logic [GroupW-1:0]              group_o,
  output recovery_pkg::error_kind_e      fault_kind_o,
  output logic                           busy_o
);

  logic [NumGroups-1:0]                      fault_mask;
  recovery_pkg::error_kind_e [NumGroups-1:0] error_kind;
  logic                                      addr_gen_en;
  logic [RfAddrWidth-2:0]                    addr;
  logic                                      addr_last;

  lockstep_checker #(
    .NumGroups (NumGroups),
    .DataWidth (DataWidth)
  ) u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_a_main_i (core_a_main_i),
    .core_b_main_i (core_b_main_i),
    .core_a_data_i (core_a_data_i),
    .core_b_data_i (core_b_data_i),
    .fault_mask_o  (fault_mask),
    .error_kind_o  (error_kind)
  );

  rf_address_generator #(
    .RfAddrWidth (RfAddrWidth)
  ) u_addr_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (addr_gen_en),
    .addr_o   (addr),
    .last_o   (addr_last)
  );

  recovery_controller #(
    .NumGroups   (NumGroups),
    .RfAddrWidth (RfAddrWidth)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fault_mask_i  (fault_mask),
    .error_kind_i  (error_kind),
    .addr_i        (addr),
    .addr_last_i   (addr_last),
    .debug_rsp_i   (debug_rsp_i),
    .addr_gen_en_o (addr_gen_en),
    .setback_o     (setback_o),
    .debug_req_o   (debug_req_o),
    .resume_o      (resume_o),
    .recover_o     (recover_o),
    .instr_lock_o  (instr_lock_o),
    .clk_en_o      (clk_en_o),
    .we_a_o        (we_a_o),
    .we_b_o        (we_b_o),
    .waddr_a_o     (waddr_a_o),
    .waddr_b_o     (waddr_b_o),
    .group_o       (group_o),
    .fault_kind_o  (fault_kind_o),
    .busy_o        (busy_o)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// free-running clock from time zero; reset is released 10 ns after the last counted rising edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // reset leaves on the same offset that the testbench uses for its inputs
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_dmr_recovery.sv
// assumes 4 groups, 32-bit core words and 5-bit register addresses; run from the project root
`timescale 1ns/1ns
`default_nettype none

module tb_dmr_recovery;

  localparam int NumGroups   = 4;
  localparam int DataWidth   = 32;
  localparam int RfAddrWidth = 5;
  localparam int GroupW      = 2;
  localparam int HalfRegs    = 2 ** (RfAddrWidth - 1);
  localparam int Width       = NumGroups * DataWidth;

  logic                      clk;
  logic                      rst_n;
  logic [Width-1:0]          a_main;
  logic [Width-1:0]          b_main;
  logic [Width-1:0]          a_data;
  logic [Width-1:0]          b_data;
  logic [NumGroups-1:0]      debug_rsp;
  logic [NumGroups-1:0]      setback;
  logic [NumGroups-1:0]      debug_req;
  logic [NumGroups-1:0]      resume;
  logic [NumGroups-1:0]      recover;
  logic [NumGroups-1:0]      instr_lock;
  logic [NumGroups-1:0]      clk_en;
  logic                      we_a;
  logic                      we_b;
  logic [RfAddrWidth-1:0]    waddr_a;
  logic [RfAddrWidth-1:0]    waddr_b;
  logic [GroupW-1:0]         group;
  recovery_pkg::error_kind_e fault_kind;
  logic                      busy;

  int                        pat_delay[$];
  int                        pat_hold[$];
  int                        pat_group[$];
  recovery_pkg::error_kind_e pat_kind[$];
  logic [Width-1:0]          pat_main_xor[$];
  logic [Width-1:0]          pat_data_xor[$];
  int                        seed = 73;
  int                        watchdog_cycles = 0;

  tb_clock_gen #(
    .PeriodNs    (100),
    .ResetCycles (5)
  ) u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dmr_recovery_top #(
    .NumGroups   (NumGroups),
    .DataWidth   (DataWidth),
    .RfAddrWidth (RfAddrWidth)
  ) DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .core_a_main_i (a_main),
    .core_b_main_i (b_main),
    .core_a_data_i (a_data),
    .core_b_data_i (b_data),
    .debug_rsp_i   (debug_rsp),
    .setback_o     (setback),
    .debug_req_o   (debug_req),
    .resume_o      (resume),
    .recover_o     (recover),
    .instr_lock_o  (instr_lock),
    .clk_en_o      (clk_en),
    .we_a_o        (we_a),
    .we_b_o        (we_b),
    .waddr_a_o     (waddr_a),
    .waddr_b_o     (waddr_b),
    .group_o       (group),
    .fault_kind_o  (fault_kind),
    .busy_o        (busy)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_mask(input string name, input logic [NumGroups-1:0] exp,
                            input logic [NumGroups-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s expected %b got %b",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input logic [RfAddrWidth-1:0] exp,
                            input logic [RfAddrWidth-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s expected %0d got %0d",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_kind(input string name, input recovery_pkg::error_kind_e exp,
                            input recovery_pkg::error_kind_e act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s expected %s got %s",
                              $time, name, exp.name(), act.name()));
    end
  endtask

  task automatic check_group(input string name, input logic [GroupW-1:0] exp,
                             input logic [GroupW-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s expected %0d got %0d",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s expected %b got %b",
                              $time, name, exp, act));
    end
  endtask

  // outputs settle from registers, so 10 ns after the edge is safe to sample and drive
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // core a gets fresh random words and core b differs only where the xor mask is set
  task automatic drive_words(input logic [Width-1:0] main_xor, input logic [Width-1:0] data_xor);
    for (int g = 0; g < NumGroups; g++) begin
      a_main[g*DataWidth +: DataWidth] = $random(seed);
      a_data[g*DataWidth +: DataWidth] = $random(seed);
    end
    b_main = a_main ^ main_xor;
    b_data = a_data ^ data_xor;
  endtask

  task automatic check_quiet();
    check_flag("busy_o", 1'b0, busy);
    check_mask("setback_o", '0, setback);
    check_mask("debug_req_o", '0, debug_req);
    check_mask("resume_o", '0, resume);
    check_mask("recover_o", '0, recover);
    check_mask("instr_lock_o", '0, instr_lock);
    check_mask("clk_en_o", '1, clk_en);
    check_flag("we_a_o", 1'b0, we_a);
    check_flag("we_b_o", 1'b0, we_b);
  endtask

  task automatic quiet_window(input int cycles);
    repeat (cycles) begin
      next_cycle();
      check_quiet();
      drive_words('0, '0);
    end
  endtask

  // starts in an idle cycle where the checker already flags the fault
  task automatic run_routine(input int g, input recovery_pkg::error_kind_e kind,
                             input int delay, input logic clear);
    logic [NumGroups-1:0] sel;
    sel = NumGroups'(1) << g;
    check_quiet();
    next_cycle();
    check_mask("setback_o", sel, setback);
    check_flag("busy_o", 1'b1, busy);
    check_group("group_o", GroupW'(g), group);
    check_kind("fault_kind_o", kind, fault_kind);
    if (clear) begin
      drive_words('0, '0);
    end
    next_cycle();
    check_mask("setback_o", '0, setback);
    check_mask("debug_req_o", sel, debug_req);
    check_mask("instr_lock_o", sel, instr_lock);
    // nothing may be written while the group is still running
    for (int i = 0; i <= delay; i++) begin
      next_cycle();
      check_mask("debug_req_o", '0, debug_req);
      check_flag("we_a_o", 1'b0, we_a);
      check_flag("we_b_o", 1'b0, we_b);
      check_mask("recover_o", '0, recover);
    end
    debug_rsp = sel;
    for (int i = 0; i < HalfRegs; i++) begin
      next_cycle();
      check_flag("we_a_o", 1'b1, we_a);
      check_flag("we_b_o", 1'b1, we_b);
      check_mask("recover_o", sel, recover);
      check_mask("instr_lock_o", sel, instr_lock);
      check_addr("waddr_a_o", RfAddrWidth'(i), waddr_a);
      check_addr("waddr_b_o", RfAddrWidth'(i + HalfRegs), waddr_b);
      check_mask("resume_o", (i == HalfRegs - 1) ? sel : '0, resume);
    end
    next_cycle();
    check_flag("busy_o", 1'b1, busy);
    check_mask("recover_o", '0, recover);
    check_mask("instr_lock_o", '0, instr_lock);
    check_mask("resume_o", '0, resume);
    check_flag("we_a_o", 1'b0, we_a);
    check_flag("we_b_o", 1'b0, we_b);
    debug_rsp = '0;
    next_cycle();
    check_quiet();
    check_group("group_o", '0, group);
  endtask

  task automatic read_patterns();
    int                   fd;
    int                   n;
    int                   delay;
    int                   hold;
    int                   grp;
    int                   kind;
    int                   max_delay;
    string                line;
    logic [DataWidth-1:0] w [8];
    max_delay = 0;
    fd = $fopen("recovery_patterns.txt", "r");
    if (fd == 0) begin
      stop_on_error("cannot open recovery_patterns.txt for reading");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %h %d %h %h %h %h %h %h %h %h", delay, hold, grp, kind,
                  w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
      if (n != 12) begin
        stop_on_error({"malformed line in the pattern file: ", line});
      end
      pat_delay.push_back(delay);
      pat_hold.push_back(hold);
      pat_group.push_back(grp);
      pat_kind.push_back(recovery_pkg::error_kind_e'(kind));
      pat_main_xor.push_back({w[6], w[4], w[2], w[0]});
      pat_data_xor.push_back({w[7], w[5], w[3], w[1]});
      if (delay > max_delay) begin
        max_delay = delay;
      end
    end
    $fclose(fd);
    if (pat_delay.size() == 0) begin
      stop_on_error("the pattern file holds no patterns");
    end
    // a held fault runs the routine twice and so doubles the time per pattern
    watchdog_cycles = pat_delay.size() * 2 * (HalfRegs + max_delay + 10) + 20;
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    stop_on_error($sformatf("simulation timed out after %0d cycles", watchdog_cycles));
  end

  initial begin
    a_main    = '0;
    b_main    = '0;
    a_data    = '0;
    b_data    = '0;
    debug_rsp = '0;
    read_patterns();
    wait (rst_n);
    next_cycle();
    check_quiet();
    for (int p = 0; p < pat_delay.size(); p++) begin
      drive_words(pat_main_xor[p], pat_data_xor[p]);
      next_cycle();
      if (pat_group[p] >= NumGroups) begin
        quiet_window(20);
      end else begin
        run_routine(pat_group[p], pat_kind[p], pat_delay[p], pat_hold[p] == 0);
        if (pat_hold[p] != 0) begin
          run_routine(pat_group[p], pat_kind[p], pat_delay[p], 1'b1);
        end
        quiet_window(3);
      end
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: recovery_patterns.txt
# delay hold group kind, then for groups 0 to 3 the main xor and data xor that core b applies
# group f means no fault; kind 0 main, 1 data, 2 both, 3 none; hold 1 keeps the fault for a rerun
0 0 f 3  00000000 00000000  00000000 00000000  00000000 00000000  00000000 00000000
0 0 0 0  00000001 00000000  00000000 00000000  00000000 00000000  00000000 00000000
3 0 2 1  00000000 00000000  00000000 00000000  00000000 80000000  00000000 00000000
5 0 3 2  00000000 00000000  00000000 00000000  00000000 00000000  00ff0000 00000010
1 0 1 1  00000000 00000000  00000000 0000a000  00000000 00000000  40000000 00000000
2 0 0 2  10000000 00000004  00000001 00000000  00000000 00000100  ffffffff ffffffff
7 0 2 0  00000000 00000000  00000000 00000000  00020000 00000000  00000008 00000000
2 1 1 0  00000000 00000000  00000800 00000000  00000000 00000000  00000000 00000000
0 0 f 3  00000000 00000000  00000000 00000000  00000000 00000000  00000000 00000000
1 1 0 1  00000000 00000400  00000000 00000000  01000000 00000000  00000000 00000000
12 0 3 0 00000000 00000000  00000000 00000000  00000000 00000000  0000c000 00000000
4 0 1 2  00000000 00000000  80000000 00000001  00000000 00000000  00000000 00000000
0 0 f 3  00000000 00000000  00000000 00000000  00000000 00000000  00000000 00000000

// File: files.f
recovery_pkg.sv
lockstep_checker.sv
rf_address_generator.sv
recovery_controller.sv
dmr_recovery_top.sv
tb_clock_gen.sv
tb_dmr_recovery.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f files.f --top-module tb_dmr_recovery -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Checks failed" "$log"; then
  echo "simulation failed, see $log"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation passed"
exit 0
